/* Bender.yml */
package:
  name: wb_interconnect

sources:
  - src/wbi_pkg.sv
  - src/wb_arb.sv
  - src/wb_addr_decode.sv
  - src/wb_bus_timer.sv
  - src/wb_req_mux.sv
  - src/wb_rsp_mux.sv
  - src/wb_interconnect.sv
  - target: test
    files:
      - verification/wb_slave_model.sv
      - verification/tb_wb_interconnect.sv

/* src/wb_addr_decode.sv */
// Address decoder: target id per master from the internal or external memory map
`default_nettype none

module wb_addr_decode import wbi_pkg::*; (
  input  wire wb_mreq_t m_req_i [N_MASTERS],
  output      wb_req_t  m_req_o [N_MASTERS]
);

  // RISC data map
  function automatic tid_t int_map(input map_nib_t nib);
    unique case (nib)
      INT_FLASH,
      INT_SPIREG: return S_SPI;
      INT_SDRAM:  return S_SDRAM;
      INT_GLBL:   return S_GLBL;
      default:    return TID_NONE;
    endcase
  endfunction

  // External map, shifted window plus shared globals
  function automatic tid_t ext_map(input map_nib_t nib);
    unique case (nib)
      EXT_FLASH,
      EXT_SPIREG: return S_SPI;
      EXT_SDRAM:  return S_SDRAM;
      EXT_GLBL:   return S_GLBL;
      default:    return TID_NONE;
    endcase
  endfunction

  // --------------------------------------------------------------------
  // Per-master tag
  // --------------------------------------------------------------------
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      m_req_o[m].mreq = m_req_i[m];
      // Region select on address bits 31:28
      if (mst_id_t'(m) == EXT_MST) begin
        m_req_o[m].tid = ext_map(m_req_i[m].adr[31:28]);
      end else begin
        m_req_o[m].tid = int_map(m_req_i[m].adr[31:28]);
      end
    end
  end

endmodule

`default_nettype wire

/* src/wb_arb.sv */
// Round-robin bus arbiter FSM over the master cyc lines
`default_nettype none

module wb_arb import wbi_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  // One cyc per master
  input  wire logic [N_MASTERS-1:0] cyc_i,
  output      mst_id_t              gnt_o
);

  arb_state_e state_q;
  arb_state_e state_d;

  // --------------------------------------------------------------------
  // Next owner
  // --------------------------------------------------------------------
  // Owner keeps the bus while its cyc is up
  // Otherwise search forward 0 -> 1 -> 2 -> 0
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      GNT0: begin
        if (!cyc_i[0]) begin
          if (cyc_i[1]) state_d = GNT1;
          else if (cyc_i[2]) state_d = GNT2;
        end
      end
      GNT1: begin
        if (!cyc_i[1]) begin
          if (cyc_i[2]) state_d = GNT2;
          else if (cyc_i[0]) state_d = GNT0;
        end
      end
      GNT2: begin
        if (!cyc_i[2]) begin
          if (cyc_i[0]) state_d = GNT0;
          else if (cyc_i[1]) state_d = GNT1;
        end
      end
      // Illegal code, recover to master 0
      default: state_d = GNT0;
    endcase
  end

  // State register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= GNT0;
    end else begin
      state_q <= state_d;
    end
  end

  // Enum code doubles as master index
  assign gnt_o = mst_id_t'(state_q);

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------
  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    state_q inside {GNT0, GNT1, GNT2}
  ) else $error("arbiter state left its encodings");

  // No preemption of a live cycle
  a_gnt_held: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cyc_i[gnt_o] |=> $stable(gnt_o)
  ) else $error("grant moved while owner held cyc");

endmodule

`default_nettype wire

/* src/wb_bus_timer.sv */
// Bus watchdog: ends an unanswered granted strobe with a timeout pulse
`default_nettype none

module wb_bus_timer import wbi_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    arst_n_i,
  // Owner's request after the mux
  input  wire wb_req_t bus_req_i,
  input  wire wb_rsp_t s_rsp_i [N_SLAVES],
  output      logic    timeout_o
);

  tmr_cnt_t cnt_q;
  logic     strobe;
  logic     answered;
  logic     expire;

  // Live strobe from the current owner
  assign strobe = bus_req_i.mreq.cyc & bus_req_i.mreq.stb;

  // Only the addressed slave sees stb, so any ack/err is ours
  always_comb begin
    answered = timeout_o;
    for (int s = 0; s < N_SLAVES; s++) begin
      answered = answered | s_rsp_i[s].ack | s_rsp_i[s].err;
    end
  end

  // Last waiting cycle
  assign expire = strobe & !answered & (cnt_q == tmr_cnt_t'(BUS_TIMEOUT - 1));

  // --------------------------------------------------------------------
  // Counter and pulse
  // --------------------------------------------------------------------
  // Pulse lands BUS_TIMEOUT cycles after first stb
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q     <= '0;
      timeout_o <= 1'b0;
    end else begin
      timeout_o <= expire;
      if (!strobe || answered || expire) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + tmr_cnt_t'(1);
      end
    end
  end

  // Single-cycle err only
  a_tmo_pulse: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    timeout_o |=> !timeout_o
  ) else $error("watchdog timeout held for two cycles");

endmodule

`default_nettype wire

/* src/wb_interconnect.sv */
// Top level: shared Wishbone bus, three masters to three slaves
`default_nettype none

module wb_interconnect import wbi_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  // Master side
  input  wire wb_mreq_t m_req_i [N_MASTERS],
  output      wb_rsp_t  m_rsp_o [N_MASTERS],
  // Slave side
  output      wb_mreq_t s_req_o [N_SLAVES],
  input  wire wb_rsp_t  s_rsp_i [N_SLAVES]
);

  // --------------------------------------------------------------------
  // Internal nets
  // --------------------------------------------------------------------
  // Tagged master requests
  wb_req_t              dec_req [N_MASTERS];
  // Arbiter inputs
  logic [N_MASTERS-1:0] m_cyc;
  mst_id_t              gnt;
  // Owner's request on the shared path
  wb_req_t              bus_req;
  logic                 timeout;

  // Request lines for the arbiter
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      m_cyc[m] = m_req_i[m].cyc;
    end
  end

  // --------------------------------------------------------------------
  // Request side
  // --------------------------------------------------------------------
  // Target id per master
  wb_addr_decode u_addr_decode (
    .m_req_i (m_req_i),
    .m_req_o (dec_req)
  );

  // Bus ownership
  wb_arb u_arb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cyc_i    (m_cyc),
    .gnt_o    (gnt)
  );

  // Owner to addressed slave
  wb_req_mux u_req_mux (
    .req_i     (dec_req),
    .gnt_i     (gnt),
    .bus_req_o (bus_req),
    .s_req_o   (s_req_o)
  );

  // --------------------------------------------------------------------
  // Response side
  // --------------------------------------------------------------------
  // Hung cycle watchdog
  wb_bus_timer u_bus_timer (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .bus_req_i (bus_req),
    .s_rsp_i   (s_rsp_i),
    .timeout_o (timeout)
  );

  // Slave answer to owner
  wb_rsp_mux u_rsp_mux (
    .bus_req_i (bus_req),
    .gnt_i     (gnt),
    .s_rsp_i   (s_rsp_i),
    .timeout_i (timeout),
    .m_rsp_o   (m_rsp_o)
  );

endmodule

`default_nettype wire

/* src/wb_req_mux.sv */
// Request mux: granted master to the decoded slave, zeros elsewhere
`default_nettype none

module wb_req_mux import wbi_pkg::*; (
  input  wire wb_req_t  req_i [N_MASTERS],
  input  wire mst_id_t  gnt_i,
  // Owner's request, for timer and response side
  output      wb_req_t  bus_req_o,
  output      wb_mreq_t s_req_o [N_SLAVES]
);

  logic [N_SLAVES-1:0] s_cyc;

  // --------------------------------------------------------------------
  // Master select
  // --------------------------------------------------------------------
  always_comb begin
    unique case (gnt_i)
      2'd0:    bus_req_o = req_i[0];
      2'd1:    bus_req_o = req_i[1];
      2'd2:    bus_req_o = req_i[2];
      // No owner, idle bus
      default: bus_req_o = '0;
    endcase
  end

  // --------------------------------------------------------------------
  // Slave steering
  // --------------------------------------------------------------------
  // TID_NONE matches no index, so all slaves idle
  always_comb begin
    for (int s = 0; s < N_SLAVES; s++) begin
      if (bus_req_o.tid == tid_t'(s)) begin
        s_req_o[s] = bus_req_o.mreq;
      end else begin
        s_req_o[s] = '0;
      end
    end
  end

  // Collected slave cyc lines
  always_comb begin
    for (int s = 0; s < N_SLAVES; s++) begin
      s_cyc[s] = s_req_o[s].cyc;
    end
  end

  // Shared path, never two slaves in a cycle
  a_one_slave: assert final ($onehot0(s_cyc))
    else $error("more than one slave sees cyc");

endmodule

`default_nettype wire

/* src/wb_rsp_mux.sv */
// Response mux: addressed slave back to the granted master, watchdog err merged
`default_nettype none

module wb_rsp_mux import wbi_pkg::*; (
  input  wire wb_req_t bus_req_i,
  input  wire mst_id_t gnt_i,
  input  wire wb_rsp_t s_rsp_i [N_SLAVES],
  input  wire logic    timeout_i,
  output      wb_rsp_t m_rsp_o [N_MASTERS]
)
;

  wb_rsp_t bus_rsp;

  // --------------------------------------------------------------------
  // Slave select
  // --------------------------------------------------------------------
  always_comb begin
    unique case (bus_req_i.tid)
      S_SPI:   bus_rsp = s_rsp_i[0];
      S_SDRAM: bus_rsp = s_rsp_i[1];
      S_GLBL:  bus_rsp = s_rsp_i[2];
      // Unmapped, only the watchdog can answer
      default: bus_rsp = '0;
    endcase
    // Watchdog ends a hung cycle
    bus_rsp.err = bus_rsp.err | timeout_i;
  end

  // --------------------------------------------------------------------
  // Return path
  // --------------------------------------------------------------------
  // Waiting masters see nothing
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      if (gnt_i == mst_id_t'(m)) begin
        m_rsp_o[m] = bus_rsp;
      end else begin
        m_rsp_o[m] = '0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/wbi_pkg.sv */
// Wishbone interconnect package: bus types, request/response structs, arbiter states, memory map
`default_nettype none

package wbi_pkg;

  // --------------------------------------------------------------------
  // Bus sizes
  // --------------------------------------------------------------------
  localparam int unsigned N_MASTERS = 3;
  localparam int unsigned N_SLAVES  = 3;

  // Watchdog limit in clock cycles
  localparam int unsigned BUS_TIMEOUT = 16;
  localparam int unsigned TMR_W       = $clog2(BUS_TIMEOUT);

  // Plain vector types
  typedef logic [31:0]      wb_adr_t;
  typedef logic [31:0]      wb_dat_t;
  typedef logic [3:0]       wb_sel_t;
  typedef logic [1:0]       tid_t;
  typedef logic [1:0]       mst_id_t;
  typedef logic [3:0]       map_nib_t;
  typedef logic [TMR_W-1:0] tmr_cnt_t;

  // Target ids, one per slave port
  localparam tid_t S_SPI    = 2'd0;
  localparam tid_t S_SDRAM  = 2'd1;
  localparam tid_t S_GLBL   = 2'd2;
  // Address hits no slave
  localparam tid_t TID_NONE = 2'd3;

  // Only this master decodes through the external map
  localparam mst_id_t EXT_MST = 2'd2;

  // --------------------------------------------------------------------
  // Memory map, top address nibble
  // --------------------------------------------------------------------
  // RISC data side
  localparam map_nib_t INT_FLASH  = 4'h0;
  localparam map_nib_t INT_SPIREG = 4'h1;
  localparam map_nib_t INT_SDRAM  = 4'h2;
  localparam map_nib_t INT_GLBL   = 4'h3;
  // External side, global regs alias the internal window
  localparam map_nib_t EXT_GLBL   = 4'h3;
  localparam map_nib_t EXT_FLASH  = 4'h4;
  localparam map_nib_t EXT_SPIREG = 4'h5;
  localparam map_nib_t EXT_SDRAM  = 4'h6;

  // --------------------------------------------------------------------
  // Bus structs
  // --------------------------------------------------------------------
  // Request as seen at master and slave ports
  typedef struct packed {
    wb_dat_t dat;
    wb_adr_t adr;
    wb_sel_t sel;
    logic    we;
    logic    cyc;
    logic    stb;
  } wb_mreq_t;

  // Request inside the fabric, with decoded target
  typedef struct packed {
    wb_mreq_t mreq;
    tid_t     tid;
  } wb_req_t;

  // Read data and termination
  typedef struct packed {
    wb_dat_t dat;
    logic    ack;
    logic    err;
  } wb_rsp_t;

  // Arbiter ownership
  typedef enum logic [1:0] {
    GNT0 = 2'd0,
    GNT1 = 2'd1,
    GNT2 = 2'd2
  } arb_state_e;

endpackage

`default_nettype wire

/* tb.f */
src/wbi_pkg.sv
src/wb_arb.sv
src/wb_addr_decode.sv
src/wb_bus_timer.sv
src/wb_req_mux.sv
src/wb_rsp_mux.sv
src/wb_interconnect.sv
verification/wb_slave_model.sv
verification/tb_wb_interconnect.sv

/* verification/tb_wb_interconnect.sv */
// Testbench: table-driven map checks, round-robin order and response isolation
`default_nettype none

module tb_wb_interconnect import wbi_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TXN_TIMEOUT = 64;
  // Expected slave for an unmapped address
  localparam int NO_SLV      = 3;

  typedef struct {
    string   name;
    int      mst;
    bit      we;
    wb_adr_t adr;
    wb_dat_t dat;
    wb_sel_t sel;
    int      slv;
    wb_dat_t rdata;
    bit      err;
  } test_t;

  logic                 clk;
  logic                 arst_n;
  wb_mreq_t             m_req [N_MASTERS];
  wb_rsp_t              m_rsp [N_MASTERS];
  wb_mreq_t             s_req [N_SLAVES];
  wb_rsp_t              s_rsp [N_SLAVES];
  test_t                tests [$];
  int                   done_order [$];
  int                   seed = 32'h4bba_6bf2;
  wb_dat_t              rnd [3];
  bit                   m0_released;
  bit                   m1_done;
  logic [N_MASTERS-1:0] rsp_hit;

  always #5 clk = ~clk;

  wb_interconnect dut_i (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .m_req_i  (m_req),
    .m_rsp_o  (m_rsp),
    .s_req_o  (s_req),
    .s_rsp_i  (s_rsp)
  );

  // Slave k answers after k+1 cycles
  for (genvar k = 0; k < N_SLAVES; k++) begin : g_slv
    wb_slave_model #(.LATENCY(k + 1)) u_slv (
      .clk_i    (clk),
      .arst_n_i (arst_n),
      .req_i    (s_req[k]),
      .rsp_o    (s_rsp[k])
    );
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic check(input string name, input logic [75:0] exp, input logic [75:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // Byte lanes of nw picked by sel, rest kept from old
  function automatic wb_dat_t merge_sel(input wb_dat_t old, input wb_dat_t nw, input wb_sel_t sel);
    wb_dat_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = nw[8*b +: 8];
    end
    return res;
  endfunction

  // Cyclic successor 0 -> 1 -> 2 -> 0 among requesters
  function automatic int next_owner(input int owner, input logic [2:0] req);
    for (int k = 1; k <= 3; k++) begin
      if (req[(owner + k) % 3]) return (owner + k) % 3;
    end
    return owner;
  endfunction

  task automatic add_test(input string name, input int mst, input bit we, input wb_adr_t adr,
                          input wb_dat_t dat, input wb_sel_t sel, input int slv,
                          input wb_dat_t rdata, input bit err);
    test_t t;
    t = '{name, mst, we, adr, dat, sel, slv, rdata, err};
    tests.push_back(t);
  endtask

  // One classic cycle on master m; solo adds slave routing checks
  task automatic drive_txn(input string name, input int m, input bit we, input wb_adr_t adr,
                           input wb_dat_t dat, input wb_sel_t sel, input bit keep_cyc,
                           input bit solo, input int exp_slv, output wb_rsp_t rsp);
    wb_mreq_t req;
    bit       seen;
    bit       done;
    int       cnt;
    req  = '{dat: dat, adr: adr, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    seen = 1'b0;
    done = 1'b0;
    cnt  = 0;
    rsp  = '0;
    @(negedge clk);
    m_req[m] = req;
    while (!done) begin
      @(posedge clk);
      if (solo) begin
        for (int s = 0; s < N_SLAVES; s++) begin
          if (s == exp_slv && s_req[s].cyc) begin
            seen = 1'b1;
            check({name, " slave request"}, req, s_req[s]);
          end else if (s != exp_slv) begin
            check({name, " idle slave cyc"}, 1'b0, s_req[s].cyc);
          end
        end
      end
      if (m_rsp[m].ack || m_rsp[m].err) begin
        rsp  = m_rsp[m];
        done = 1'b1;
      end else if (cnt >= TXN_TIMEOUT) begin
        $display("Simulation failed");
        $fatal(1, "%s: master %0d saw no ack or err in %0d cycles", name, m, TXN_TIMEOUT);
      end
      cnt++;
    end
    if (solo && exp_slv != NO_SLV) check({name, " slave reached"}, 1'b1, seen);
    // Drop stb, and cyc unless the grant is kept
    @(negedge clk);
    if (keep_cyc) m_req[m].stb = 1'b0;
    else m_req[m] = '0;
  endtask

  // Responses only to one master, and only to one with cyc up
  always @(posedge clk) begin
    if (arst_n) begin
      for (int m = 0; m < N_MASTERS; m++) begin
        rsp_hit[m] = m_rsp[m].ack | m_rsp[m].err;
        if (rsp_hit[m]) check("response to idle master", 1'b1, m_req[m].cyc);
      end
      check("single master response", 1'b1, $onehot0(rsp_hit));
    end
  end

  // ------------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------------
  initial begin
    wb_rsp_t rsp;
    wb_rsp_t rsp0;
    wb_rsp_t rsp1;
    wb_rsp_t rsp2;
    clk         = 1'b0;
    arst_n      = 1'b0;
    m0_released = 1'b0;
    m1_done     = 1'b0;
    for (int m = 0; m < N_MASTERS; m++) m_req[m] = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // Idle bus after reset
    @(posedge clk);
    for (int s = 0; s < N_SLAVES; s++) begin
      check("reset slave cyc", 1'b0, s_req[s].cyc);
      check("reset slave stb", 1'b0, s_req[s].stb);
    end
    for (int m = 0; m < N_MASTERS; m++) begin
      check("reset master ack", 1'b0, m_rsp[m].ack);
      check("reset master err", 1'b0, m_rsp[m].err);
    end
    for (int i = 0; i < 3; i++) rnd[i] = $random(seed);
    // Internal map, masters 0 and 1
    add_test("int m0 wr 0", 0, 1, 32'h0000_0004, 32'hA5A5_0001, 4'hF, 0, '0, 0);
    add_test("int m1 wr 1", 1, 1, 32'h1000_0008, 32'h5A5A_0002, 4'h3, 0, '0, 0);
    add_test("int m1 wr 2", 1, 1, 32'h2000_000C, 32'h1234_5678, 4'h6, 1, '0, 0);
    add_test("int m0 wr 3", 0, 1, 32'h3000_0000, 32'h0BAD_F00D, 4'hF, 2, '0, 0);
    add_test("int m1 rd 0", 1, 0, 32'h0000_0004, '0, 4'hF, 0, 32'hA5A5_0001, 0);
    add_test("int m0 rd 1", 0, 0, 32'h1000_0008, '0, 4'hF, 0, merge_sel('0, 32'h5A5A_0002, 4'h3), 0);
    add_test("int m0 rd 2", 0, 0, 32'h2000_000C, '0, 4'hF, 1, merge_sel('0, 32'h1234_5678, 4'h6), 0);
    add_test("int m1 rd 3", 1, 0, 32'h3000_0000, '0, 4'hF, 2, 32'h0BAD_F00D, 0);
    // External map writes, read back through the internal map
    add_test("ext m2 wr 4", 2, 1, 32'h4000_0010, rnd[0], 4'hF, 0, '0, 0);
    add_test("ext m2 wr 6", 2, 1, 32'h6000_0020, rnd[1], 4'h3, 1, '0, 0);
    add_test("ext m2 wr 3", 2, 1, 32'h3000_0030, rnd[2], 4'hC, 2, '0, 0);
    add_test("ext m0 rd 0", 0, 0, 32'h0000_0010, '0, 4'hF, 0, rnd[0], 0);
    add_test("ext m0 rd 2", 0, 0, 32'h2000_0020, '0, 4'hF, 1, merge_sel('0, rnd[1], 4'h3), 0);
    add_test("ext m0 rd 3", 0, 0, 32'h3000_0030, '0, 4'hF, 2, merge_sel('0, rnd[2], 4'hC), 0);
    // Nibble 7 hits nothing in either map
    add_test("unmapped m0", 0, 1, 32'h7000_0000, 32'hFFFF_FFFF, 4'hF, NO_SLV, '0, 1);
    add_test("unmapped m1", 1, 0, 32'h7000_0004, '0, 4'hF, NO_SLV, '0, 1);
    add_test("unmapped m2", 2, 0, 32'h7000_0008, '0, 4'hF, NO_SLV, '0, 1);
    foreach (tests[i]) begin
      drive_txn(tests[i].name, tests[i].mst, tests[i].we, tests[i].adr, tests[i].dat,
                tests[i].sel, 1'b0, 1'b1, tests[i].slv, rsp);
      check({tests[i].name, " err"}, tests[i].err, rsp.err);
      check({tests[i].name, " ack"}, !tests[i].err, rsp.ack);
      if (!tests[i].we || tests[i].err) check({tests[i].name, " rdata"}, tests[i].rdata, rsp.dat);
    end
    // Master 0 keeps cyc over two cycles, master 1 must wait
    fork
      begin
        drive_txn("rr m0 first", 0, 1, 32'h0000_0020, 32'hC0DE_0001, 4'hF, 1, 0, 0, rsp0);
        drive_txn("rr m0 second", 0, 0, 32'h0000_0020, '0, 4'hF, 0, 0, 0, rsp0);
        check("rr m0 read back", 32'hC0DE_0001, rsp0.dat);
        m0_released = 1'b1;
      end
      begin
        @(negedge clk);
        drive_txn("rr m1 held", 1, 1, 32'h2000_0030, 32'hBEEF_0002, 4'hF, 0, 0, 1, rsp1);
        m1_done = 1'b1;
      end
      begin
        for (int c = 0; c < 4 * TXN_TIMEOUT && !m1_done; c++) begin
          @(posedge clk);
          for (int s = 0; s < N_SLAVES; s++) begin
            if (s_req[s].stb && s_req[s].adr == 32'h2000_0030) begin
              check("rr m1 held off", 1'b1, m0_released);
            end
          end
        end
      end
    join
    // Masters 1 and 2 raise cyc together while master 0 owns the bus
    fork
      begin
        drive_txn("rr m0 owner", 0, 0, 32'h3000_0000, '0, 4'hF, 0, 0, 2, rsp0);
        done_order.push_back(0);
      end
      begin
        @(negedge clk);
        drive_txn("rr m1 contend", 1, 0, 32'h2000_0030, '0, 4'hF, 0, 0, 1, rsp1);
        done_order.push_back(1);
      end
      begin
        @(negedge clk);
        drive_txn("rr m2 contend", 2, 0, 32'h6000_0030, '0, 4'hF, 0, 0, 1, rsp2);
        done_order.push_back(2);
      end
    join
    check("rr m0 data", 32'h0BAD_F00D, rsp0.dat);
    check("rr m1 data", 32'hBEEF_0002, rsp1.dat);
    check("rr m2 data", 32'hBEEF_0002, rsp2.dat);
    check("rr owner done", 0, done_order[0]);
    check("rr first waiter", next_owner(0, 3'b110), done_order[1]);
    check("rr second waiter", next_owner(next_owner(0, 3'b110), 3'b100), done_order[2]);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/wb_slave_model.sv */
// Behavioral Wishbone slave: 16-word memory, byte selects, fixed ack latency
`default_nettype none

module wb_slave_model import wbi_pkg::*; #(
  // Cycles from first strobe to ack
  parameter int unsigned LATENCY = 1
) (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire wb_mreq_t req_i,
  output      wb_rsp_t  rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  wb_dat_t     mem [16];
  int unsigned wait_q;
  logic [3:0]  widx;

  // Word index from address bits 5:2
  assign widx = req_i.adr[5:2];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_o  <= '0;
      wait_q <= 0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else if (rsp_o.ack) begin
      // One ack per strobe
      rsp_o <= '0;
    end else if (req_i.cyc && req_i.stb) begin
      if (wait_q == LATENCY - 1) begin
        wait_q    <= 0;
        rsp_o.ack <= 1'b1;
        if (req_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (req_i.sel[b]) begin
              mem[widx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
          end
        end else begin
          rsp_o.dat <= mem[widx];
        end
      end else begin
        wait_q <= wait_q + 1;
      end
    end else begin
      wait_q <= 0;
    end
  end

endmodule

`default_nettype wire
